// File: logic/proc_defines.svh
// ------------------------------
// control unit widths, RV32 opcode
// fields and manager CSR numbers
// ------------------------------

`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

// field widths
`define PROC_INST_W          32
`define PROC_RADDR_W         5
`define PROC_CSR_W           12

// manager CSRs
`define PROC_CSR_PROC2MNGR   12'h7C0
`define PROC_CSR_MNGR2PROC   12'hFC0

// RV32 major opcodes
`define PROC_OPC_OP          7'b0110011
`define PROC_OPC_OP_IMM      7'b0010011
`define PROC_OPC_LUI         7'b0110111
`define PROC_OPC_AUIPC       7'b0010111
`define PROC_OPC_LOAD        7'b0000011
`define PROC_OPC_STORE       7'b0100011
`define PROC_OPC_BRANCH      7'b1100011
`define PROC_OPC_JAL         7'b1101111
`define PROC_OPC_JALR        7'b1100111
`define PROC_OPC_SYSTEM      7'b1110011

`endif

// File: logic/proc_pkg.sv
// ------------------------------
// control enums and bundles shared
// by the pipeline control blocks
// ------------------------------

`include "proc_defines.svh"

package proc_pkg;

  // alu ops, encoding matches the datapath alu
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl,
    alu_sra, alu_slt, alu_sltu, alu_lui, alu_cp0, alu_cp1, alu_auipc
  } alu_fn_e;

  typedef enum logic [2:0] {
    br_none, br_bne, br_beq, br_blt, br_bltu, br_bge, br_bgeu
  } br_type_e;

  typedef enum logic [1:0] {jt_none, jt_jal, jt_jalr} jump_type_e;
  typedef enum logic {op1_rf, op1_pc} op1_sel_e;
  typedef enum logic [1:0] {op2_rf, op2_imm, op2_csr} op2_sel_e;
  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j, imm_shamt} imm_type_e;
  typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_type_e;

  // F pc mux
  typedef enum logic [1:0] {pc_plus4, pc_branch, pc_jal, pc_jalr} pc_sel_e;

  // X result mux
  typedef enum logic {ex_pc4, ex_alu} ex_sel_e;

  // decoded fields of the instruction in D
  typedef struct packed {
    logic                     inst_val;
    br_type_e                 br_type;
    jump_type_e               jump_type;
    imm_type_e                imm_type;
    op1_sel_e                 op1_sel;
    op2_sel_e                 op2_sel;
    logic                     rs1_en;
    logic                     rs2_en;
    alu_fn_e                  alu_fn;
    mem_type_e                mem_type;
    logic                     wb_sel;
    ex_sel_e                  ex_sel;
    logic                     rf_wen;
    logic [`PROC_RADDR_W-1:0] rs1;
    logic [`PROC_RADDR_W-1:0] rs2;
    logic [`PROC_RADDR_W-1:0] rd;
    logic                     proc2mngr;
    logic                     mngr2proc;
  } dec_ctrl_t;

  // writeback tag kept in X, M and W
  typedef struct packed {
    logic                     val;
    logic                     rf_wen_pending;
    logic [`PROC_RADDR_W-1:0] rf_waddr;
  } wb_tag_t;

endpackage

// File: logic/inst_decoder.sv
// ------------------------------
// instruction decoder
// maps the word in D to the control bundle
// ------------------------------

`timescale 1ns/100ps

`include "proc_defines.svh"

module inst_decoder import proc_pkg::*; (
  input  logic [`PROC_INST_W-1:0] inst_i,
  output dec_ctrl_t               ctrl_o
);

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [`PROC_CSR_W-1:0] csr;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign csr    = inst_i[31:20];

  always_comb begin
    // defaults, everything off
    ctrl_o        = '0;
    ctrl_o.rs1    = inst_i[19:15];
    ctrl_o.rs2    = inst_i[24:20];
    ctrl_o.rd     = inst_i[11:7];
    ctrl_o.ex_sel = ex_alu;

    case (opcode)
      // ------------------------------
      // reg-reg
      `PROC_OPC_OP: begin
        ctrl_o.inst_val = 1'b1;
        ctrl_o.rs1_en   = 1'b1;
        ctrl_o.rs2_en   = 1'b1;
        ctrl_o.rf_wen   = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: ctrl_o.alu_fn = alu_add;
          {7'h20, 3'b000}: ctrl_o.alu_fn = alu_sub;
          {7'h00, 3'b001}: ctrl_o.alu_fn = alu_sll;
          {7'h00, 3'b010}: ctrl_o.alu_fn = alu_slt;
          {7'h00, 3'b011}: ctrl_o.alu_fn = alu_sltu;
          {7'h00, 3'b100}: ctrl_o.alu_fn = alu_xor;
          {7'h00, 3'b101}: ctrl_o.alu_fn = alu_srl;
          {7'h20, 3'b101}: ctrl_o.alu_fn = alu_sra;
          {7'h00, 3'b110}: ctrl_o.alu_fn = alu_or;
          {7'h00, 3'b111}: ctrl_o.alu_fn = alu_and;
          default:         ctrl_o.inst_val = 1'b0;
        endcase
      end
      // ------------------------------
      // reg-imm, shifts take shamt
      `PROC_OPC_OP_IMM: begin
        ctrl_o.inst_val = 1'b1;
        ctrl_o.rs1_en   = 1'b1;
        ctrl_o.rf_wen   = 1'b1;
        ctrl_o.op2_sel  = op2_imm;
        case (funct3)
          3'b000: ctrl_o.alu_fn = alu_add;
          3'b010: ctrl_o.alu_fn = alu_slt;
          3'b011: ctrl_o.alu_fn = alu_sltu;
          3'b100: ctrl_o.alu_fn = alu_xor;
          3'b110: ctrl_o.alu_fn = alu_or;
          3'b111: ctrl_o.alu_fn = alu_and;
          default: ctrl_o.imm_type = imm_shamt;
        endcase
        if (funct3 == 3'b001) begin
          ctrl_o.alu_fn   = alu_sll;
          ctrl_o.inst_val = (funct7 == 7'h00);
        end
        if (funct3 == 3'b101) begin
          ctrl_o.alu_fn   = (funct7 == 7'h20) ? alu_sra : alu_srl;
          ctrl_o.inst_val = (funct7 == 7'h00) || (funct7 == 7'h20);
        end
      end
      `PROC_OPC_LUI, `PROC_OPC_AUIPC: begin
        ctrl_o.inst_val = 1'b1;
        ctrl_o.rf_wen   = 1'b1;
        ctrl_o.imm_type = imm_u;
        ctrl_o.op2_sel  = op2_imm;
        // auipc adds the immediate to pc
        ctrl_o.op1_sel  = (opcode == `PROC_OPC_AUIPC) ? op1_pc : op1_rf;
        ctrl_o.alu_fn   = (opcode == `PROC_OPC_AUIPC) ? alu_auipc : alu_lui;
      end
      // ------------------------------
      // memory, word access only
      `PROC_OPC_LOAD: begin
        ctrl_o.inst_val = (funct3 == 3'b010);
        ctrl_o.rs1_en   = 1'b1;
        ctrl_o.op2_sel  = op2_imm;
        ctrl_o.mem_type = mem_load;
        ctrl_o.wb_sel   = 1'b1;
        ctrl_o.rf_wen   = 1'b1;
      end
      `PROC_OPC_STORE: begin
        ctrl_o.inst_val = (funct3 == 3'b010);
        ctrl_o.rs1_en   = 1'b1;
        ctrl_o.rs2_en   = 1'b1;
        ctrl_o.imm_type = imm_s;
        ctrl_o.op2_sel  = op2_imm;
        ctrl_o.mem_type = mem_store;
      end
      // ------------------------------
      // control flow
      `PROC_OPC_BRANCH: begin
        ctrl_o.inst_val = (funct3 != 3'b010) && (funct3 != 3'b011);
        ctrl_o.rs1_en   = 1'b1;
        ctrl_o.rs2_en   = 1'b1;
        ctrl_o.imm_type = imm_b;
        case (funct3)
          3'b000:  ctrl_o.br_type = br_beq;
          3'b001:  ctrl_o.br_type = br_bne;
          3'b100:  ctrl_o.br_type = br_blt;
          3'b101:  ctrl_o.br_type = br_bge;
          3'b110:  ctrl_o.br_type = br_bltu;
          default: ctrl_o.br_type = br_bgeu;
        endcase
      end
      `PROC_OPC_JAL: begin
        ctrl_o.inst_val  = 1'b1;
        ctrl_o.imm_type  = imm_j;
        ctrl_o.op1_sel   = op1_pc;
        ctrl_o.op2_sel   = op2_imm;
        ctrl_o.jump_type = jt_jal;
        ctrl_o.ex_sel    = ex_pc4;
        ctrl_o.rf_wen    = 1'b1;
      end
      `PROC_OPC_JALR: begin
        // target is rs1 + imm, link is pc+4
        ctrl_o.inst_val  = (funct3 == 3'b000);
        ctrl_o.rs1_en    = 1'b1;
        ctrl_o.op2_sel   = op2_imm;
        ctrl_o.jump_type = jt_jalr;
        ctrl_o.ex_sel    = ex_pc4;
        ctrl_o.rf_wen    = 1'b1;
      end
      // ------------------------------
      // csrr is csrrs rd,csr,x0 and csrw is csrrw x0,csr,rs1
      `PROC_OPC_SYSTEM: begin
        if (funct3 == 3'b010 && inst_i[19:15] == '0 && csr == `PROC_CSR_MNGR2PROC) begin
          ctrl_o.inst_val  = 1'b1;
          ctrl_o.op2_sel   = op2_csr;
          ctrl_o.alu_fn    = alu_cp1;
          ctrl_o.rf_wen    = 1'b1;
          ctrl_o.mngr2proc = 1'b1;
        end
        if (funct3 == 3'b001 && inst_i[11:7] == '0 && csr == `PROC_CSR_PROC2MNGR) begin
          ctrl_o.inst_val  = 1'b1;
          ctrl_o.rs1_en    = 1'b1;
          ctrl_o.alu_fn    = alu_cp0;
          ctrl_o.proc2mngr = 1'b1;
        end
      end
      default: ctrl_o.inst_val = 1'b0;
    endcase

    // unknown word, no side effects at all
    if (!ctrl_o.inst_val) begin
      ctrl_o.rs1_en    = 1'b0;
      ctrl_o.rs2_en    = 1'b0;
      ctrl_o.rf_wen    = 1'b0;
      ctrl_o.mem_type  = mem_none;
      ctrl_o.br_type   = br_none;
      ctrl_o.jump_type = jt_none;
      ctrl_o.proc2mngr = 1'b0;
      ctrl_o.mngr2proc = 1'b0;
    end
  end

endmodule

// File: logic/hazard_unit.sv
// ------------------------------
// hazard unit
// raw check of D sources vs X, M, W
// ------------------------------

`timescale 1ns/100ps

`include "proc_defines.svh"

module hazard_unit import proc_pkg::*; (
  input  dec_ctrl_t ctrl_i,
  input  wb_tag_t   tag_x_i,
  input  wb_tag_t   tag_m_i,
  input  wb_tag_t   tag_w_i,
  output logic      hazard_o
);

  // one source against one stage, x0 never conflicts
  function automatic logic raw_hit(
    input wb_tag_t                  tag,
    input logic                     src_en,
    input logic [`PROC_RADDR_W-1:0] src
  );
    raw_hit = src_en && tag.val && tag.rf_wen_pending
              && (tag.rf_waddr == src) && (tag.rf_waddr != '0);
  endfunction

  logic hit_rs1;
  logic hit_rs2;

  // rs1 against all three producers
  assign hit_rs1 = raw_hit(tag_x_i, ctrl_i.rs1_en, ctrl_i.rs1)
                || raw_hit(tag_m_i, ctrl_i.rs1_en, ctrl_i.rs1)
                || raw_hit(tag_w_i, ctrl_i.rs1_en, ctrl_i.rs1);

  // rs2 likewise
  assign hit_rs2 = raw_hit(tag_x_i, ctrl_i.rs2_en, ctrl_i.rs2)
                || raw_hit(tag_m_i, ctrl_i.rs2_en, ctrl_i.rs2)
                || raw_hit(tag_w_i, ctrl_i.rs2_en, ctrl_i.rs2);

  // not qualified with val_D here
  assign hazard_o = hit_rs1 || hit_rs2;

endmodule

// File: logic/mem_port_arbiter.sv
// ------------------------------
// memory port arbiter
// data over fetch on one request port
// ------------------------------

`timescale 1ns/100ps

module mem_port_arbiter (
  input  logic clk,
  input  logic reset,
  input  logic imem_req_i,
  input  logic dmem_req_i,
  input  logic memreq_rdy_i,
  output logic imem_gnt_o,
  output logic dmem_gnt_o,
  output logic memreq_val_o,
  output logic memreq_sel_o
);

  logic port_on_q;
  logic port_on;

  // port opens the cycle after reset drops
  always_ff @(posedge clk) begin
    if (reset) begin
      port_on_q <= 1'b0;
    end else begin
      port_on_q <= 1'b1;
    end
  end

  assign port_on = port_on_q && !reset;

  // fixed priority, data first
  assign dmem_gnt_o = port_on && dmem_req_i && memreq_rdy_i;
  assign imem_gnt_o = port_on && imem_req_i && !dmem_req_i && memreq_rdy_i;

  assign memreq_val_o = port_on && (dmem_req_i || imem_req_i);
  // 1 selects data
  assign memreq_sel_o = dmem_req_i;

endmodule

// File: logic/pipe_ctrl.sv
// ------------------------------
// pipeline control, valid, stall and
// squash per stage plus branch resolve
// ------------------------------

`timescale 1ns/100ps

`include "proc_defines.svh"

module pipe_ctrl import proc_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  dec_ctrl_t                ctrl_i,
  input  logic                     hazard_i,
  input  logic                     imem_gnt_i,
  input  logic                     dmem_gnt_i,
  input  logic                     imemresp_val_i,
  input  logic                     dmemresp_val_i,
  input  logic                     mngr2proc_val_i,
  input  logic                     proc2mngr_rdy_i,
  input  logic                     br_eq_x_i,
  input  logic                     br_lt_x_i,
  input  logic                     br_ltu_x_i,
  output wb_tag_t                  tag_x_o,
  output wb_tag_t                  tag_m_o,
  output wb_tag_t                  tag_w_o,
  output logic                     imem_req_o,
  output logic                     dmem_req_o,
  output logic                     imemresp_rdy_o,
  output logic                     imemresp_drop_o,
  output logic                     dmemresp_rdy_o,
  output logic                     mngr2proc_rdy_o,
  output logic                     proc2mngr_val_o,
  output logic                     reg_en_f_o,
  output logic                     reg_en_d_o,
  output logic                     reg_en_x_o,
  output logic                     reg_en_m_o,
  output logic                     reg_en_w_o,
  output pc_sel_e                  pc_sel_f_o,
  output op1_sel_e                 op1_sel_d_o,
  output op2_sel_e                 op2_sel_d_o,
  output imm_type_e                imm_type_d_o,
  output alu_fn_e                  alu_fn_x_o,
  output ex_sel_e                  ex_sel_x_o,
  output logic                     wb_sel_m_o,
  output logic [`PROC_RADDR_W-1:0] rf_waddr_w_o,
  output logic                     rf_wen_w_o,
  output logic                     commit_o
);

  logic      val_f;
  logic      val_d;
  wb_tag_t   tag_x_q;
  wb_tag_t   tag_m_q;
  wb_tag_t   tag_w_q;
  dec_ctrl_t ctrl_x_q;
  dec_ctrl_t ctrl_m_q;
  logic      p2m_w_q;

  logic ostall_f;
  logic ostall_d;
  logic ostall_x;
  logic ostall_m;
  logic ostall_w;
  logic stall_f;
  logic stall_d;
  logic stall_x;
  logic stall_m;
  logic stall_w;
  logic osquash_d;
  logic osquash_x;
  logic squash_f;
  logic squash_d;
  logic redirect_d;
  logic redirect_x;
  pc_sel_e pc_sel_x;

  // ------------------------------
  // ostall per stage
  // ------------------------------
  assign ostall_f = val_f && !imemresp_val_i;
  // csrr waits on the manager
  assign ostall_d = val_d && (hazard_i || (ctrl_i.mngr2proc && !mngr2proc_val_i));
  assign ostall_x = tag_x_q.val && (ctrl_x_q.mem_type != mem_none) && !dmem_gnt_i;
  assign ostall_m = tag_m_q.val && (ctrl_m_q.mem_type != mem_none) && !dmemresp_val_i;
  assign ostall_w = tag_w_q.val && p2m_w_q && !proc2mngr_rdy_i;

  // own ostall or anything downstream
  assign stall_w = tag_w_q.val && ostall_w;
  assign stall_m = tag_m_q.val && (ostall_m || ostall_w);
  assign stall_x = tag_x_q.val && (ostall_x || ostall_m || ostall_w);
  assign stall_d = val_d && (ostall_d || ostall_x || ostall_m || ostall_w);
  assign stall_f = val_f && (ostall_f || ostall_d || ostall_x || ostall_m || ostall_w);

  // ------------------------------
  // redirects and squash
  // ------------------------------
  assign redirect_d = val_d && (ctrl_i.jump_type == jt_jal);

  // branch outcome from the datapath compare flags
  always_comb begin
    redirect_x = 1'b0;
    pc_sel_x   = pc_branch;
    case (ctrl_x_q.br_type)
      br_bne:  redirect_x = !br_eq_x_i;
      br_beq:  redirect_x = br_eq_x_i;
      br_blt:  redirect_x = br_lt_x_i;
      br_bltu: redirect_x = br_ltu_x_i;
      br_bge:  redirect_x = !br_lt_x_i;
      br_bgeu: redirect_x = !br_ltu_x_i;
      default: redirect_x = 1'b0;
    endcase
    if (ctrl_x_q.jump_type == jt_jalr) begin
      redirect_x = 1'b1;
      pc_sel_x   = pc_jalr;
    end
    redirect_x = redirect_x && tag_x_q.val;
  end

  // X wins over D
  assign pc_sel_f_o = redirect_x ? pc_sel_x : (redirect_d ? pc_jal : pc_plus4);

  // no squash from a stalled stage, it would fire twice
  assign osquash_d = redirect_d && !stall_d;
  assign osquash_x = redirect_x && !stall_x;
  assign squash_f  = val_f && (osquash_d || osquash_x);
  assign squash_d  = val_d && osquash_x;

  // ------------------------------
  // F, fetch goes out ahead of F
  // ------------------------------
  assign imem_req_o      = !stall_f || squash_f;
  assign imemresp_rdy_o  = !stall_f || squash_f;
  assign imemresp_drop_o = squash_f;
  // pc only moves when the fetch was issued
  assign reg_en_f_o      = imem_req_o && imem_gnt_i;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
    end else if (imem_req_o) begin
      val_f <= imem_gnt_i;
    end
  end

  // ------------------------------
  // D
  // ------------------------------
  assign reg_en_d_o      = !stall_d || squash_d;
  assign mngr2proc_rdy_o = val_d && !stall_d && ctrl_i.mngr2proc;
  assign op1_sel_d_o     = ctrl_i.op1_sel;
  assign op2_sel_d_o     = ctrl_i.op2_sel;
  assign imm_type_d_o    = ctrl_i.imm_type;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (reg_en_d_o) begin
      val_d <= val_f && !stall_f && !squash_f;
    end
  end

  // ------------------------------
  // X, M and W
  // ------------------------------
  assign reg_en_x_o = !stall_x;
  assign reg_en_m_o = !stall_m;
  assign reg_en_w_o = !stall_w;

  // request while downstream is free, transfer on grant
  assign dmem_req_o = tag_x_q.val && (ctrl_x_q.mem_type != mem_none)
                      && !ostall_m && !ostall_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      tag_x_q <= '0;
      tag_m_q <= '0;
      tag_w_q <= '0;
    end else begin
      if (reg_en_x_o) begin
        tag_x_q  <= '{val: val_d && !stall_d && !squash_d,
                      rf_wen_pending: ctrl_i.rf_wen, rf_waddr: ctrl_i.rd};
        ctrl_x_q <= ctrl_i;
      end
      if (reg_en_m_o) begin
        tag_m_q  <= '{val: tag_x_q.val && !stall_x,
                      rf_wen_pending: tag_x_q.rf_wen_pending, rf_waddr: tag_x_q.rf_waddr};
        ctrl_m_q <= ctrl_x_q;
      end
      if (reg_en_w_o) begin
        tag_w_q  <= '{val: tag_m_q.val && !stall_m,
                      rf_wen_pending: tag_m_q.rf_wen_pending, rf_waddr: tag_m_q.rf_waddr};
        p2m_w_q  <= ctrl_m_q.proc2mngr;
      end
    end
  end

  assign alu_fn_x_o     = ctrl_x_q.alu_fn;
  assign ex_sel_x_o     = ctrl_x_q.ex_sel;
  assign wb_sel_m_o     = ctrl_m_q.wb_sel;
  assign dmemresp_rdy_o = tag_m_q.val && !stall_m && (ctrl_m_q.mem_type != mem_none);

  // W side effects only on valid, unstalled
  assign rf_waddr_w_o    = tag_w_q.rf_waddr;
  assign rf_wen_w_o      = tag_w_q.val && tag_w_q.rf_wen_pending;
  assign proc2mngr_val_o = tag_w_q.val && !stall_w && p2m_w_q;
  assign commit_o        = tag_w_q.val && !stall_w;

  assign tag_x_o = tag_x_q;
  assign tag_m_o = tag_m_q;
  assign tag_w_o = tag_w_q;

endmodule

// File: logic/proc_ctrl_top.sv
// ------------------------------
// control unit top, decoder, hazard
// unit, pipe control and memory arbiter
// ------------------------------

`timescale 1ns/100ps

`include "proc_defines.svh"

module proc_ctrl_top import proc_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`PROC_INST_W-1:0]  inst_d_i,
  // memory
  input  logic                     memreq_rdy_i,
  output logic                     memreq_val_o,
  output logic                     memreq_sel_o,
  input  logic                     imemresp_val_i,
  output logic                     imemresp_rdy_o,
  output logic                     imemresp_drop_o,
  input  logic                     dmemresp_val_i,
  output logic                     dmemresp_rdy_o,
  // manager
  input  logic                     mngr2proc_val_i,
  output logic                     mngr2proc_rdy_o,
  output logic                     proc2mngr_val_o,
  input  logic                     proc2mngr_rdy_i,
  // datapath status
  input  logic                     br_eq_x_i,
  input  logic                     br_lt_x_i,
  input  logic                     br_ltu_x_i,
  // datapath control
  output logic                     reg_en_f_o,
  output logic                     reg_en_d_o,
  output logic                     reg_en_x_o,
  output logic                     reg_en_m_o,
  output logic                     reg_en_w_o,
  output pc_sel_e                  pc_sel_f_o,
  output op1_sel_e                 op1_sel_d_o,
  output op2_sel_e                 op2_sel_d_o,
  output imm_type_e                imm_type_d_o,
  output alu_fn_e                  alu_fn_x_o,
  output ex_sel_e                  ex_sel_x_o,
  output logic                     wb_sel_m_o,
  output logic [`PROC_RADDR_W-1:0] rf_waddr_w_o,
  output logic                     rf_wen_w_o,
  output logic                     commit_o
);

  dec_ctrl_t dec_ctrl;
  wb_tag_t   tag_x;
  wb_tag_t   tag_m;
  wb_tag_t   tag_w;
  logic      hazard;
  logic      imem_req;
  logic      dmem_req;
  logic      imem_gnt;
  logic      dmem_gnt;

  inst_decoder u_dec (
    .inst_i (inst_d_i),
    .ctrl_o (dec_ctrl)
  );

  hazard_unit u_haz (
    .ctrl_i   (dec_ctrl),
    .tag_x_i  (tag_x),
    .tag_m_i  (tag_m),
    .tag_w_i  (tag_w),
    .hazard_o (hazard)
  );

  // remaining ports share names with the top
  pipe_ctrl u_pipe (
    .ctrl_i     (dec_ctrl),
    .hazard_i   (hazard),
    .imem_gnt_i (imem_gnt),
    .dmem_gnt_i (dmem_gnt),
    .tag_x_o    (tag_x),
    .tag_m_o    (tag_m),
    .tag_w_o    (tag_w),
    .imem_req_o (imem_req),
    .dmem_req_o (dmem_req),
    .*
  );

  mem_port_arbiter u_arb (
    .clk          (clk),
    .reset        (reset),
    .imem_req_i   (imem_req),
    .dmem_req_i   (dmem_req),
    .memreq_rdy_i (memreq_rdy_i),
    .imem_gnt_o   (imem_gnt),
    .dmem_gnt_o   (dmem_gnt),
    .memreq_val_o (memreq_val_o),
    .memreq_sel_o (memreq_sel_o)
  );

endmodule

// File: test/proc_ctrl_assert.sv
// ------------------------------
// pipe control assertions
// ------------------------------

`timescale 1ns/100ps

module proc_ctrl_assert import proc_pkg::*; (
  input logic    clk,
  input logic    reset,
  input logic    rf_wen_w_o,
  input logic    commit_o,
  input logic    imemresp_drop_o,
  input pc_sel_e pc_sel_f_o,
  input logic    dmem_gnt_i,
  input logic    reg_en_x_o
);

  // count of failed assertions
  int unsigned fail_cnt = 0;

  // register write only from a W that commits
  wen_needs_commit: assert property (@(posedge clk) disable iff (reset)
    rf_wen_w_o |-> commit_o)
    else begin
      $error("rf write from a stalled or empty W stage");
      fail_cnt++;
    end

  // a dropped fetch always comes with a pc redirect
  drop_has_redirect: assert property (@(posedge clk) disable iff (reset)
    imemresp_drop_o |-> pc_sel_f_o != pc_plus4)
    else begin
      $error("fetch response dropped without a redirect");
      fail_cnt++;
    end

  // a granted data request moves X on
  gnt_moves_x: assert property (@(posedge clk) disable iff (reset)
    dmem_gnt_i |-> reg_en_x_o)
    else begin
      $error("X held after its data request was granted");
      fail_cnt++;
    end

endmodule

bind pipe_ctrl proc_ctrl_assert u_assert (.*);

// File: test/proc_ctrl_tb.sv
// ------------------------------
// control unit testbench, trace driven
// ------------------------------

`timescale 1ns/100ps

`include "proc_defines.svh"

module proc_ctrl_tb import proc_pkg::*; ();

  localparam logic [31:0] NOP = 32'h00000013;
  localparam int REC_W = 10;
  localparam int MAX_REC = 64;

  logic clk;
  logic reset;
  logic [`PROC_INST_W-1:0] inst_d_i;
  logic memreq_rdy_i;
  logic memreq_val_o;
  logic memreq_sel_o;
  logic imemresp_val_i;
  logic imemresp_rdy_o;
  logic imemresp_drop_o;
  logic dmemresp_val_i;
  logic dmemresp_rdy_o;
  logic mngr2proc_val_i;
  logic mngr2proc_rdy_o;
  logic proc2mngr_val_o;
  logic proc2mngr_rdy_i;
  logic br_eq_x_i;
  logic br_lt_x_i;
  logic br_ltu_x_i;
  logic reg_en_f_o;
  logic reg_en_d_o;
  logic reg_en_x_o;
  logic reg_en_m_o;
  logic reg_en_w_o;
  pc_sel_e   pc_sel_f_o;
  op1_sel_e  op1_sel_d_o;
  op2_sel_e  op2_sel_d_o;
  imm_type_e imm_type_d_o;
  alu_fn_e   alu_fn_x_o;
  ex_sel_e   ex_sel_x_o;
  logic wb_sel_m_o;
  logic [`PROC_RADDR_W-1:0] rf_waddr_w_o;
  logic rf_wen_w_o;
  logic commit_o;

  logic [31:0] trace [0:REC_W*MAX_REC-1];

  proc_ctrl_top uut (.*);

  always #5 clk = ~clk;

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
      $display("Some tests failed");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  task automatic fail_run(input string msg);
    $display("%s at %0t", msg, $time);
    $display("Some tests failed");
    $fatal(1, "stopping the run");
  endtask

  // a failed bound assertion ends the run at once
  always @(negedge clk) begin
    if (uut.u_pipe.u_assert.fail_cnt != 0) fail_run("bound assertion failed");
  end

  // hold the word in D until it moves on, count stalled cycles
  task automatic issue(input logic [31:0] inst, output int stalls);
    logic go;
    int   k;
    stalls = 0;
    go = 1'b0;
    inst_d_i = inst;
    for (k = 0; k < 20 && !go; k++) begin
      @(negedge clk);
      go = reg_en_d_o;
      @(posedge clk);
      #1;
      if (!go) stalls++;
    end
    if (!go) fail_run("timeout, instruction never left decode");
    inst_d_i = NOP;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // nops until the pipe is full and quiet again
  task automatic drain();
    inst_d_i = NOP;
    repeat (6) next_cycle();
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int r;
    int i;
    int n;
    int delay;
    logic seen;
    logic [31:0] kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] cond;
    logic [31:0] e [0:5];

    void'($urandom(32'h65a8));
    clk = 1'b0;
    reset = 1'b1;
    inst_d_i = NOP;
    memreq_rdy_i = 1'b1;
    imemresp_val_i = 1'b1;
    dmemresp_val_i = 1'b1;
    mngr2proc_val_i = 1'b1;
    proc2mngr_rdy_i = 1'b1;
    br_eq_x_i = 1'b0;
    br_lt_x_i = 1'b0;
    br_ltu_x_i = 1'b0;
    $readmemh("test/ctrl_trace.txt", trace);

    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    drain();

    r = 0;
    while (r < MAX_REC && trace[r*REC_W] !== 32'hF) begin
      kind = trace[r*REC_W];
      a    = trace[r*REC_W+1];
      b    = trace[r*REC_W+2];
      cond = trace[r*REC_W+3];
      for (i = 0; i < 6; i++) e[i] = trace[r*REC_W+4+i];

      case (kind)
        // decode fields in D, then X, then W
        0: begin
          inst_d_i = a;
          #1;
          check(op2_sel_d_o, e[2], "op2_sel in D");
          check(imm_type_d_o, e[3], "imm_type in D");
          // auipc starts from the pc, reg-reg ops from rs1
          if (a[6:0] == `PROC_OPC_AUIPC) check(op1_sel_d_o, op1_pc, "op1_sel pc in D");
          if (a[6:0] == `PROC_OPC_OP) check(op1_sel_d_o, op1_rf, "op1_sel rf in D");
          issue(a, n);
          @(negedge clk);
          check(alu_fn_x_o, e[0], "alu_fn in X");
          check(ex_sel_x_o, e[1], "ex_sel in X");
          next_cycle();
          next_cycle();
          @(negedge clk);
          check(rf_wen_w_o, e[4], "rf_wen in W");
          check(commit_o, e[5], "commit in W");
        end
        // branch or jalr resolved in X
        1: begin
          br_eq_x_i = cond[0];
          issue(a, n);
          #1;
          check(pc_sel_f_o, e[0], "pc_sel from X");
          check(imemresp_drop_o, e[1], "imem drop from X");
          br_eq_x_i = 1'b0;
        end
        // jal seen while still in D
        2: begin
          inst_d_i = a;
          #1;
          check(pc_sel_f_o, e[0], "pc_sel from D");
          check(imemresp_drop_o, e[1], "imem drop from D");
          issue(a, n);
        end
        3: begin
          issue(a, n);
          issue(b, n);
          check(n, e[0], "raw stall cycles");
        end
        // load held in M on a late response
        4: begin
          dmemresp_val_i = 1'b0;
          delay = cond + $urandom % 3;
          issue(a, n);
          @(negedge clk);
          check(memreq_val_o, 1'b1, "memreq val for load");
          check(memreq_sel_o, 1'b1, "memreq sel picks data");
          next_cycle();
          for (i = 0; i < delay; i++) begin
            @(negedge clk);
            check(reg_en_m_o, 1'b0, "M held without response");
            check(dmemresp_rdy_o, 1'b0, "dmem resp rdy while held");
            // upstream X freezes, W drains
            check(reg_en_x_o, 1'b0, "X frozen behind M");
            check(reg_en_w_o, 1'b1, "W drains under M");
            // the op ahead of the load retires and F refills once first
            if (i > 0) begin
              check(commit_o, 1'b0, "no commit behind stalled M");
              check(reg_en_f_o, 1'b0, "F frozen behind M");
              check(imemresp_rdy_o, 1'b0, "imem resp rdy while F frozen");
            end
            next_cycle();
          end
          dmemresp_val_i = 1'b1;
          @(negedge clk);
          check(reg_en_m_o, 1'b1, "M released by response");
          check(dmemresp_rdy_o, 1'b1, "dmem resp rdy on transfer");
          check(wb_sel_m_o, 1'b1, "load writes back memory data");
          seen = 1'b0;
          for (i = 0; i < 10 && !seen; i++) begin
            @(negedge clk);
            seen = commit_o;
          end
          if (!seen) fail_run("timeout, load never committed");
          check(rf_wen_w_o, e[0], "load rf_wen in W");
          check(rf_waddr_w_o, a[11:7], "load rf_waddr in W");
        end
        // csrr waits on the manager
        5: begin
          mngr2proc_val_i = 1'b0;
          inst_d_i = a;
          for (i = 0; i < cond; i++) begin
            @(negedge clk);
            check(reg_en_d_o, 1'b0, "csrr held in D");
            check(mngr2proc_rdy_o, 1'b0, "mngr2proc rdy while held");
            next_cycle();
          end
          mngr2proc_val_i = 1'b1;
          @(negedge clk);
          check(reg_en_d_o, 1'b1, "csrr leaves D");
          check(mngr2proc_rdy_o, 1'b1, "mngr2proc rdy on transfer");
          next_cycle();
          inst_d_i = NOP;
        end
        // csrw waits in W for the manager
        6: begin
          proc2mngr_rdy_i = 1'b0;
          issue(a, n);
          next_cycle();
          next_cycle();
          for (i = 0; i < cond; i++) begin
            @(negedge clk);
            check(proc2mngr_val_o, 1'b0, "proc2mngr val while not ready");
            check(commit_o, 1'b0, "csrw commit while not ready");
            next_cycle();
          end
          proc2mngr_rdy_i = 1'b1;
          @(negedge clk);
          check(proc2mngr_val_o, 1'b1, "proc2mngr val when ready");
          check(commit_o, 1'b1, "csrw commit when ready");
          next_cycle();
        end
        default: fail_run("unknown scenario kind in trace");
      endcase
      drain();
      r++;
    end

    if (uut.u_pipe.u_assert.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+logic
logic/proc_pkg.sv
logic/inst_decoder.sv
logic/hazard_unit.sv
logic/mem_port_arbiter.sv
logic/pipe_ctrl.sv
logic/proc_ctrl_top.sv
test/proc_ctrl_assert.sv
test/proc_ctrl_tb.sv

// File: Bender.yml
package:
  name: proc_ctrl

sources:
  - include_dirs:
      - logic
    files:
      - logic/proc_pkg.sv
      - logic/inst_decoder.sv
      - logic/hazard_unit.sv
      - logic/mem_port_arbiter.sv
      - logic/pipe_ctrl.sv
      - logic/proc_ctrl_top.sv
  - target: test
    files:
      - test/proc_ctrl_assert.sv
      - test/proc_ctrl_tb.sv

// File: test/ctrl_trace.txt
// kind inst_a inst_b cond e0 e1 e2 e3 e4 e5
// kind 0 decode: e0 alu_fn, e1 ex_sel, e2 op2_sel, e3 imm_type, e4 rf_wen, e5 commit
0 002082B3 00000000 0 0 1 0 0 1 1
0 40208333 00000000 0 1 1 0 0 1 1
0 0050C393 00000000 0 4 1 1 0 1 1
0 00309413 00000000 0 5 1 1 5 1 1
0 123454B7 00000000 0 A 1 1 3 1 1
0 00001517 00000000 0 D 1 1 3 1 1
0 0000A583 00000000 0 0 1 1 0 1 1
0 0020A223 00000000 0 0 1 1 1 0 1
0 FFFFFFFF 00000000 0 0 1 0 0 0 1
0 FC002673 00000000 0 C 1 2 0 1 1
0 7C009073 00000000 0 B 1 0 0 0 1
0 000000E7 00000000 0 0 0 1 0 1 1
// kind 1 redirect in X: cond br_eq, e0 pc_sel, e1 drop
1 00208463 00000000 1 1 1 0 0 0 0
1 00208463 00000000 0 0 0 0 0 0 0
1 000000E7 00000000 0 3 1 0 0 0 0
// kind 2 jal in D: e0 pc_sel, e1 drop
2 010000EF 00000000 0 2 1 0 0 0 0
// kind 3 raw pair: e0 stall cycles of the consumer
3 002082B3 000281B3 0 3 0 0 0 0 0
3 00108013 000001B3 0 0 0 0 0 0 0
// kind 4 load: cond base response delay, e0 rf_wen in W
4 0000A583 00000000 2 1 0 0 0 0 0
// kind 5 csrr, kind 6 csrw: cond manager delay
5 FC002673 00000000 3 0 0 0 0 0 0
6 7C009073 00000000 3 0 0 0 0 0 0
F 00000000 00000000 0 0 0 0 0 0 0
